//--- build.f
+incdir+.
cp0Pkg.sv
cp0ExcCtrl.sv
cp0StatusCause.sv
cp0Timer.sv
cp0ExcRegs.sv
cp0Top.sv
cp0_assertions.sv
cp0Tb.sv

//--- cp0ExcCtrl.sv
// CP0 control: address decode, EXL state, exception entry and eret redirect, read mux
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0ExcCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             cp0Wen_i,
    input  cp0Pkg::cp0Addr_t cp0Addr_i,
    input  cp0Pkg::word_t    cp0WrData_i,
    input  logic             excValid_i,
    input  logic             excDelaySlot_i,
    input  logic             eret_i,
    input  cp0Pkg::excCode_t excCode_i,
    input  cp0Pkg::word_t    status_i,
    input  cp0Pkg::word_t    cause_i,
    input  cp0Pkg::word_t    epc_i,
    input  cp0Pkg::word_t    badVaddr_i,
    input  cp0Pkg::word_t    count_i,
    input  cp0Pkg::word_t    compare_i,
    output logic             wrStatus_o,
    output logic             wrCause_o,
    output logic             wrEpc_o,
    output logic             wrCount_o,
    output logic             wrCompare_o,
    output logic             takeExc_o,
    output logic             capBadVaddr_o,
    output logic             exl_o,
    output cp0Pkg::word_t    cp0RdData_o,
    output logic             cp0ExcOccur_o,
    output cp0Pkg::word_t    cp0ExcDestPc_o
);

    cp0Pkg::excLevel_t excLevel;
    logic              addrCode;

    // ------------------------------
    // write decode
    // ------------------------------
    assign wrStatus_o  = cp0Wen_i && (cp0Addr_i == `CP0_ADDR_STATUS);
    assign wrCause_o   = cp0Wen_i && (cp0Addr_i == `CP0_ADDR_CAUSE);
    assign wrEpc_o     = cp0Wen_i && (cp0Addr_i == `CP0_ADDR_EPC);
    assign wrCount_o   = cp0Wen_i && (cp0Addr_i == `CP0_ADDR_COUNT);
    assign wrCompare_o = cp0Wen_i && (cp0Addr_i == `CP0_ADDR_COMPARE);

    // ------------------------------
    // exception entry
    // ------------------------------
    // nested exceptions are ignored while in a handler
    assign takeExc_o = excValid_i && (excLevel == cp0Pkg::EXC_NORMAL);

    // address errors and TLB faults load BadVAddr
    assign addrCode = (excCode_i == `EXC_ADEL) || (excCode_i == `EXC_ADES) ||
                      (excCode_i == `EXC_TLBL) || (excCode_i == `EXC_TLBS) ||
                      (excCode_i == `EXC_MOD);
    assign capBadVaddr_o = takeExc_o && addrCode;

    // software write wins over entry, entry over eret
    always_ff @(posedge clk) begin
        if (!rst) begin
            excLevel <= cp0Pkg::EXC_NORMAL;
        end else if (wrStatus_o) begin
            excLevel <= cp0WrData_i[`STATUS_EXL] ? cp0Pkg::EXC_LEVEL : cp0Pkg::EXC_NORMAL;
        end else if (takeExc_o) begin
            excLevel <= cp0Pkg::EXC_LEVEL;
        end else if (eret_i) begin
            excLevel <= cp0Pkg::EXC_NORMAL;
        end
    end

    assign exl_o = (excLevel == cp0Pkg::EXC_LEVEL);

    // ------------------------------
    // redirect to pipeline front
    // ------------------------------
    assign cp0ExcOccur_o = takeExc_o || eret_i;

    always_comb begin
        if (takeExc_o) begin
            cp0ExcDestPc_o = `CP0_EXC_VECTOR;
        end else if (eret_i) begin
            cp0ExcDestPc_o = epc_i;
        end else begin
            cp0ExcDestPc_o = '0;
        end
    end

    // ------------------------------
    // move-from read mux
    // ------------------------------
    always_comb begin
        case (cp0Addr_i)
            `CP0_ADDR_STATUS:   cp0RdData_o = status_i;
            `CP0_ADDR_CAUSE:    cp0RdData_o = cause_i;
            `CP0_ADDR_EPC:      cp0RdData_o = epc_i;
            `CP0_ADDR_BADVADDR: cp0RdData_o = badVaddr_i;
            `CP0_ADDR_COUNT:    cp0RdData_o = count_i;
            `CP0_ADDR_COMPARE:  cp0RdData_o = compare_i;
            // unimplemented registers read as zero
            default:            cp0RdData_o = '0;
        endcase
    end

endmodule

//--- cp0ExcRegs.sv
// CP0 EPC and BadVAddr, captured on exception entry
`timescale 1ns/100ps

module cp0ExcRegs (
    input  logic          clk,
    input  logic          takeExc_i,
    input  logic          capBadVaddr_i,
    input  logic          wrEpc_i,
    input  logic          excDelaySlot_i,
    input  cp0Pkg::word_t excPc_i,
    input  cp0Pkg::word_t excBadVaddr_i,
    input  cp0Pkg::word_t wrData_i,
    output cp0Pkg::word_t epc_o,
    output cp0Pkg::word_t badVaddr_o
);

    cp0Pkg::word_t epc;
    cp0Pkg::word_t badVaddr;
    cp0Pkg::word_t excRestartPc;

    // ------------------------------
    // EPC
    // ------------------------------
    // in a delay slot the handler restarts at the branch
    assign excRestartPc = excDelaySlot_i ? (excPc_i - 32'd4) : excPc_i;

    // hardware capture wins over mtc0
    always_ff @(posedge clk) begin
        if (takeExc_i) begin
            epc <= excRestartPc;
        end else if (wrEpc_i) begin
            epc <= wrData_i;
        end
    end

    // ------------------------------
    // BadVAddr
    // ------------------------------
    // read-only to software
    always_ff @(posedge clk) begin
        if (capBadVaddr_i) begin
            badVaddr <= excBadVaddr_i;
        end
    end

    assign epc_o      = epc;
    assign badVaddr_o = badVaddr;

endmodule

//--- cp0Pkg.sv
// CP0 shared types: data word, register address, cause code, interrupt lines, EXL state
package cp0Pkg;

    // data word or virtual address
    typedef logic [31:0] word_t;

    // {rd, sel} register position
    typedef logic [7:0] cp0Addr_t;

    // exception cause code as stored in Cause
    typedef logic [4:0] excCode_t;

    // hardware interrupt pins
    typedef logic [5:0] intLines_t;

    // ------------------------------
    // exception level
    // ------------------------------
    // normal mode or inside a handler (Status.EXL)
    typedef enum logic {
        EXC_NORMAL = 1'b0,
        EXC_LEVEL  = 1'b1
    } excLevel_t;

endpackage

//--- cp0StatusCause.sv
// CP0 Status and Cause fields, with interrupt pin sampling and timer interrupt flag
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0StatusCause (
    input  logic              clk,
    input  logic              rst,
    input  logic              wrStatus_i,
    input  logic              wrCause_i,
    input  cp0Pkg::word_t     wrData_i,
    input  logic              takeExc_i,
    input  logic              excDelaySlot_i,
    input  logic              timerHit_i,
    input  logic              wrCompare_i,
    input  logic              exl_i,
    input  cp0Pkg::excCode_t  excCode_i,
    input  cp0Pkg::intLines_t extInt_i,
    output cp0Pkg::word_t     status_o,
    output cp0Pkg::word_t     cause_o
);

    logic [7:0]       statusIm;
    logic             statusIe;
    logic             causeBd;
    logic             causeTi;
    logic [7:0]       causeIp;
    cp0Pkg::excCode_t causeExc;

    // ------------------------------
    // Status
    // ------------------------------
    // interrupt mask keeps its value across reset
    always_ff @(posedge clk) begin
        if (wrStatus_i) begin
            statusIm <= wrData_i[`STATUS_IM_HI:`STATUS_IM_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            statusIe <= 1'b0;
        end else if (wrStatus_i) begin
            statusIe <= wrData_i[`STATUS_IE];
        end
    end

    // ------------------------------
    // Cause
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeBd  <= 1'b0;
            causeExc <= '0;
        end else if (takeExc_i) begin
            causeBd  <= excDelaySlot_i;
            causeExc <= excCode_i;
        end
    end

    // compare write acknowledges the timer
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeTi <= 1'b0;
        end else if (wrCompare_i) begin
            causeTi <= 1'b0;
        end else if (timerHit_i) begin
            causeTi <= 1'b1;
        end
    end

    // hardware lines sampled every cycle, IP7 shared with the timer
    always_ff @(posedge clk) begin
        if (!rst) begin
            causeIp <= '0;
        end else begin
            causeIp[7]   <= extInt_i[5] || causeTi;
            causeIp[6:2] <= extInt_i[4:0];
            if (wrCause_i) begin
                // only the two software interrupt bits are writable
                causeIp[1:0] <= wrData_i[`CAUSE_IP_LO+1:`CAUSE_IP_LO];
            end
        end
    end

    // ------------------------------
    // register images
    // ------------------------------
    always_comb begin
        status_o                                = '0;
        status_o[`CP0_STATUS_BEV]               = 1'b1;
        status_o[`STATUS_IM_HI:`STATUS_IM_LO]   = statusIm;
        status_o[`STATUS_EXL]                   = exl_i;
        status_o[`STATUS_IE]                    = statusIe;
    end

    always_comb begin
        cause_o                                 = '0;
        cause_o[`CAUSE_BD]                      = causeBd;
        cause_o[`CAUSE_TI]                      = causeTi;
        cause_o[`CAUSE_IP_HI:`CAUSE_IP_LO]      = causeIp;
        cause_o[`CAUSE_EXC_HI:`CAUSE_EXC_LO]    = causeExc;
    end

endmodule

//--- cp0Tb.sv
// CP0 testbench driving random register traffic, exceptions and erets against a cycle model
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0Tb;

    localparam int NUM_CYCLES = 3000;
    localparam int TIMER_WAIT = 40;

    logic              clk;
    logic              rst;
    logic              cp0Wen;
    cp0Pkg::cp0Addr_t  cp0Addr;
    cp0Pkg::word_t     cp0WrData;
    logic              excValid;
    cp0Pkg::excCode_t  excCode;
    logic              excDelaySlot;
    cp0Pkg::word_t     excPc;
    cp0Pkg::word_t     excBadVaddr;
    logic              eret;
    cp0Pkg::intLines_t extInt;
    cp0Pkg::word_t     cp0RdData;
    logic              cp0ExcOccur;
    cp0Pkg::word_t     cp0ExcDestPc;
    cp0Pkg::word_t     cp0Status;
    cp0Pkg::word_t     cp0Cause;

    // stimulus applied at the next rising edge
    logic              nRst;
    logic              nWen;
    cp0Pkg::cp0Addr_t  nAddr;
    cp0Pkg::word_t     nData;
    logic              nExc;
    cp0Pkg::excCode_t  nCode;
    logic              nDs;
    cp0Pkg::word_t     nPc;
    cp0Pkg::word_t     nBv;
    logic              nEret;
    cp0Pkg::intLines_t nInt;

    // reference model state
    cp0Pkg::word_t     mCount;
    cp0Pkg::word_t     mCompare;
    cp0Pkg::word_t     mEpc;
    cp0Pkg::word_t     mBadVaddr;
    logic [7:0]        mIm;
    logic [7:0]        mIp;
    cp0Pkg::excCode_t  mExc;
    logic              mExl;
    logic              mIe;
    logic              mBd;
    logic              mTi;
    logic              mTick;
    // registers without reset stay unknown until first loaded
    logic              imKnown;
    logic              epcKnown;
    logic              bvKnown;

    logic [31:0]       lcgState;
    int                errors;
    int                otherErrors;
    int                excTaken;
    int                excIgnored;
    int                eretCount;
    int                bvCaptures;
    int                bvHeld;
    int                timerHits;

    cp0Top cp0Top_i (
        .clk(clk), .rst(rst),
        .cp0Wen_i(cp0Wen), .cp0Addr_i(cp0Addr), .cp0WrData_i(cp0WrData),
        .excValid_i(excValid), .excCode_i(excCode), .excDelaySlot_i(excDelaySlot),
        .excPc_i(excPc), .excBadVaddr_i(excBadVaddr), .eret_i(eret), .extInt_i(extInt),
        .cp0RdData_o(cp0RdData), .cp0ExcOccur_o(cp0ExcOccur),
        .cp0ExcDestPc_o(cp0ExcDestPc), .cp0Status_o(cp0Status), .cp0Cause_o(cp0Cause)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // random source
    // ------------------------------
    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic cp0Pkg::word_t randWord();
        logic [15:0] hi;
        hi = lcgNext();
        return {hi, lcgNext()};
    endfunction

    function automatic cp0Pkg::cp0Addr_t pickAddr(input logic [2:0] sel);
        case (sel)
            3'd0:    return `CP0_ADDR_STATUS;
            3'd1:    return `CP0_ADDR_CAUSE;
            3'd2:    return `CP0_ADDR_EPC;
            3'd3:    return `CP0_ADDR_BADVADDR;
            3'd4:    return `CP0_ADDR_COUNT;
            3'd5:    return `CP0_ADDR_COMPARE;
            3'd6:    return 8'h78;
            default: return 8'h00;
        endcase
    endfunction

    function automatic cp0Pkg::excCode_t addrCodeAt(input logic [2:0] idx);
        case (idx)
            3'd0:    return `EXC_ADEL;
            3'd1:    return `EXC_ADES;
            3'd2:    return `EXC_TLBL;
            3'd3:    return `EXC_TLBS;
            default: return `EXC_MOD;
        endcase
    endfunction

    function automatic logic isAddrCode(input cp0Pkg::excCode_t code);
        return code == `EXC_ADEL || code == `EXC_ADES || code == `EXC_TLBL ||
               code == `EXC_TLBS || code == `EXC_MOD;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic cp0Pkg::word_t modelStatus();
        cp0Pkg::word_t s;
        s = 32'h0;
        s[`CP0_STATUS_BEV] = 1'b1;
        s[`STATUS_IM_HI:`STATUS_IM_LO] = mIm;
        s[`STATUS_EXL] = mExl;
        s[`STATUS_IE] = mIe;
        return s;
    endfunction

    function automatic cp0Pkg::word_t modelCause();
        cp0Pkg::word_t c;
        c = 32'h0;
        c[`CAUSE_BD] = mBd;
        c[`CAUSE_TI] = mTi;
        c[`CAUSE_IP_HI:`CAUSE_IP_LO] = mIp;
        c[`CAUSE_EXC_HI:`CAUSE_EXC_LO] = mExc;
        return c;
    endfunction

    function automatic cp0Pkg::word_t modelRead(input cp0Pkg::cp0Addr_t addr);
        case (addr)
            `CP0_ADDR_STATUS:   return modelStatus();
            `CP0_ADDR_CAUSE:    return modelCause();
            `CP0_ADDR_EPC:      return mEpc;
            `CP0_ADDR_BADVADDR: return mBadVaddr;
            `CP0_ADDR_COUNT:    return mCount;
            `CP0_ADDR_COMPARE:  return mCompare;
            default:            return 32'h0;
        endcase
    endfunction

    // advance the model by one edge with the inputs of the ending cycle
    task automatic updateModel();
        logic tk;
        logic hit;
        logic isAddr;
        logic wrSt;
        logic wrCa;
        logic wrEp;
        logic wrCn;
        logic wrCm;
        tk = excValid && !mExl;
        hit = (mCount == mCompare);
        isAddr = isAddrCode(excCode);
        wrSt = cp0Wen && cp0Addr == `CP0_ADDR_STATUS;
        wrCa = cp0Wen && cp0Addr == `CP0_ADDR_CAUSE;
        wrEp = cp0Wen && cp0Addr == `CP0_ADDR_EPC;
        wrCn = cp0Wen && cp0Addr == `CP0_ADDR_COUNT;
        wrCm = cp0Wen && cp0Addr == `CP0_ADDR_COMPARE;
        if (wrSt) begin
            mIm = cp0WrData[`STATUS_IM_HI:`STATUS_IM_LO];
            imKnown = 1'b1;
        end
        if (tk) begin
            mEpc = excDelaySlot ? excPc - 32'd4 : excPc;
            epcKnown = 1'b1;
        end else if (wrEp) begin
            mEpc = cp0WrData;
            epcKnown = 1'b1;
        end
        if (tk && isAddr) begin
            mBadVaddr = excBadVaddr;
            bvKnown = 1'b1;
        end
        if (!rst) begin
            mExl = 1'b0;
            mIe = 1'b0;
            mBd = 1'b0;
            mExc = 5'h0;
            mTi = 1'b0;
            mIp = 8'h0;
            mCount = 32'h0;
            mCompare = 32'h0;
            mTick = 1'b0;
        end else begin
            excTaken += int'(tk);
            excIgnored += int'(excValid && mExl);
            eretCount += int'(eret && !tk);
            bvCaptures += int'(tk && isAddr);
            bvHeld += int'(tk && !isAddr);
            timerHits += int'(hit && !mTi && !wrCm);
            // IP7 sees TI from before this edge
            mIp[7] = extInt[5] | mTi;
            mIp[6:2] = extInt[4:0];
            if (wrCa) begin
                mIp[1:0] = cp0WrData[`CAUSE_IP_LO+1:`CAUSE_IP_LO];
            end
            if (wrCm) begin
                mTi = 1'b0;
            end else if (hit) begin
                mTi = 1'b1;
            end
            if (wrSt) begin
                mExl = cp0WrData[`STATUS_EXL];
            end else if (tk) begin
                mExl = 1'b1;
            end else if (eret) begin
                mExl = 1'b0;
            end
            if (wrSt) begin
                mIe = cp0WrData[`STATUS_IE];
            end
            if (tk) begin
                mBd = excDelaySlot;
                mExc = excCode;
            end
            if (wrCn) begin
                mCount = cp0WrData;
            end else if (mTick) begin
                mCount = mCount + 32'd1;
            end
            mTick = 1'b1;
            if (wrCm) begin
                mCompare = cp0WrData;
            end
        end
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    task automatic checkWord(input string name, input cp0Pkg::word_t expVal,
                             input cp0Pkg::word_t actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %08h actual %08h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %b actual %b",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic checkOutputs();
        logic          tk;
        cp0Pkg::word_t dest;
        cp0Pkg::word_t destMask;
        cp0Pkg::word_t sMask;
        cp0Pkg::word_t rMask;
        tk = excValid && !mExl;
        dest = tk ? `CP0_EXC_VECTOR : (eret ? mEpc : 32'h0);
        destMask = (!tk && eret && !epcKnown) ? 32'h0 : 32'hFFFF_FFFF;
        sMask = imKnown ? 32'hFFFF_FFFF : 32'hFFFF_00FF;
        case (cp0Addr)
            `CP0_ADDR_STATUS:   rMask = sMask;
            `CP0_ADDR_EPC:      rMask = epcKnown ? 32'hFFFF_FFFF : 32'h0;
            `CP0_ADDR_BADVADDR: rMask = bvKnown ? 32'hFFFF_FFFF : 32'h0;
            default:            rMask = 32'hFFFF_FFFF;
        endcase
        checkFlag("cp0ExcOccur_o", tk || eret, cp0ExcOccur);
        checkWord("cp0ExcDestPc_o", dest & destMask, cp0ExcDestPc & destMask);
        checkWord("cp0Status_o", modelStatus() & sMask, cp0Status & sMask);
        checkWord("cp0Cause_o", modelCause(), cp0Cause);
        checkWord("cp0RdData_o", modelRead(cp0Addr) & rMask, cp0RdData & rMask);
    endtask

    task automatic requireEvent(input string what, input int count);
        if (count == 0) begin
            otherErrors++;
            $display("Stimulus never produced: %s", what);
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic setIdle();
        nWen = 1'b0;
        nAddr = `CP0_ADDR_STATUS;
        nData = 32'h0;
        nExc = 1'b0;
        nCode = 5'h0;
        nDs = 1'b0;
        nPc = 32'h0;
        nBv = 32'h0;
        nEret = 1'b0;
        nInt = 6'h0;
    endtask

    task automatic setWrite(input cp0Pkg::cp0Addr_t addr, input cp0Pkg::word_t data);
        setIdle();
        nWen = 1'b1;
        nAddr = addr;
        nData = data;
    endtask

    task automatic setException(input cp0Pkg::excCode_t code, input logic ds,
                                input cp0Pkg::word_t pc, input cp0Pkg::word_t bv);
        setIdle();
        nExc = 1'b1;
        nCode = code;
        nDs = ds;
        nPc = pc;
        nBv = bv;
    endtask

    task automatic pickRandom();
        logic [15:0]   r;
        logic [15:0]   c;
        cp0Pkg::word_t w;
        r = lcgNext();
        c = lcgNext();
        w = randWord();
        setIdle();
        nAddr = pickAddr(r[2:0]);
        nInt = c[15:10];
        case (r[5:3])
            3'd0, 3'd1: begin
                nWen = 1'b1;
                nData = w;
                if (nAddr == `CP0_ADDR_STATUS) begin
                    nData[`STATUS_EXL] = r[6] & r[7];
                end
                // compare slightly ahead of count so the timer fires
                if (nAddr == `CP0_ADDR_COMPARE && r[6]) begin
                    nData = mCount + 32'(r[9:7]) + 32'd3;
                end
            end
            3'd2: begin
                nExc = 1'b1;
                nCode = c[0] ? addrCodeAt(c[3:1]) : c[8:4];
                nDs = c[9];
                nPc = {w[31:2], 2'b00};
                nBv = randWord();
                nWen = r[6];
                nData = {w[15:0], w[31:16]};
            end
            3'd3: nEret = 1'b1;
            default: ;
        endcase
    endtask

    task automatic runCycle();
        @(posedge clk);
        updateModel();
        rst <= nRst;
        cp0Wen <= nWen;
        cp0Addr <= nAddr;
        cp0WrData <= nData;
        excValid <= nExc;
        excCode <= nCode;
        excDelaySlot <= nDs;
        excPc <= nPc;
        excBadVaddr <= nBv;
        eret <= nEret;
        extInt <= nInt;
        @(negedge clk);
        checkOutputs();
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int waited;
        lcgState = 32'd28892;
        errors = 0;
        otherErrors = 0;
        excTaken = 0;
        excIgnored = 0;
        eretCount = 0;
        bvCaptures = 0;
        bvHeld = 0;
        timerHits = 0;
        imKnown = 1'b0;
        epcKnown = 1'b0;
        bvKnown = 1'b0;
        rst = 1'b0;
        cp0Wen = 1'b0;
        cp0Addr = `CP0_ADDR_STATUS;
        cp0WrData = 32'h0;
        excValid = 1'b0;
        excCode = 5'h0;
        excDelaySlot = 1'b0;
        excPc = 32'h0;
        excBadVaddr = 32'h0;
        eret = 1'b0;
        extInt = 6'h0;
        nRst = 1'b0;
        setIdle();
        repeat (3) runCycle();
        nRst = 1'b1;
        runCycle();

        // handler setup followed by an address error in a delay slot
        setWrite(`CP0_ADDR_STATUS, 32'h0000_FF01);
        runCycle();
        setWrite(`CP0_ADDR_EPC, 32'h8000_1000);
        runCycle();
        setException(`EXC_ADEL, 1'b1, 32'h8000_2004, 32'h1234_5678);
        runCycle();
        // nested exception is ignored
        setException(5'h08, 1'b0, 32'h8000_3000, 32'hDEAD_BEEF);
        runCycle();
        setIdle();
        nEret = 1'b1;
        runCycle();
        // syscall-type code must not touch BadVAddr
        setException(5'h0A, 1'b0, 32'h8000_4000, 32'h0BAD_0BAD);
        runCycle();
        setIdle();
        nEret = 1'b1;
        runCycle();

        // compare write clears TI before the timer match
        setWrite(`CP0_ADDR_COMPARE, mCount + 32'd8);
        runCycle();
        setIdle();
        runCycle();
        waited = 0;
        while (cp0Cause[`CAUSE_TI] !== 1'b1 && waited < TIMER_WAIT) begin
            runCycle();
            waited++;
        end
        if (cp0Cause[`CAUSE_TI] !== 1'b1) begin
            otherErrors++;
            $display("Timer interrupt did not rise within %0d cycles", TIMER_WAIT);
        end
        setIdle();
        nInt = 6'b10_1101;
        runCycle();
        setIdle();
        runCycle();

        repeat (NUM_CYCLES) begin
            pickRandom();
            runCycle();
        end
        setIdle();
        runCycle();

        requireEvent("taken exception", excTaken);
        requireEvent("exception ignored under EXL", excIgnored);
        requireEvent("eret", eretCount);
        requireEvent("BadVAddr capture", bvCaptures);
        requireEvent("exception without BadVAddr capture", bvHeld);
        requireEvent("timer hit", timerHits);
        $display("Mismatches: %0d, other errors: %0d", errors, otherErrors);
        if (errors == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- cp0Timer.sv
// CP0 Count and Compare timer, raises a hit when the two registers match
`timescale 1ns/100ps

module cp0Timer (
    input  logic          clk,
    input  logic          rst,
    input  logic          wrCount_i,
    input  logic          wrCompare_i,
    input  cp0Pkg::word_t wrData_i,
    output cp0Pkg::word_t count_o,
    output cp0Pkg::word_t compare_o,
    output logic          timerHit_o
);

    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;
    logic          tick;

    // ------------------------------
    // Count
    // ------------------------------
    // delays the first increment by one cycle after reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            tick <= 1'b0;
        end else begin
            tick <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (wrCount_i) begin
            count <= wrData_i;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    // ------------------------------
    // Compare
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            compare <= '0;
        end else if (wrCompare_i) begin
            compare <= wrData_i;
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerHit_o = (count == compare);

endmodule

//--- cp0Top.sv
// CP0 top level: control block with Status/Cause, timer and exception registers
`timescale 1ns/100ps

module cp0Top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cp0Wen_i,
    input  cp0Pkg::cp0Addr_t  cp0Addr_i,
    input  cp0Pkg::word_t     cp0WrData_i,
    input  logic              excValid_i,
    input  cp0Pkg::excCode_t  excCode_i,
    input  logic              excDelaySlot_i,
    input  cp0Pkg::word_t     excPc_i,
    input  cp0Pkg::word_t     excBadVaddr_i,
    input  logic              eret_i,
    input  cp0Pkg::intLines_t extInt_i,
    output cp0Pkg::word_t     cp0RdData_o,
    output logic              cp0ExcOccur_o,
    output cp0Pkg::word_t     cp0ExcDestPc_o,
    output cp0Pkg::word_t     cp0Status_o,
    output cp0Pkg::word_t     cp0Cause_o
);

    logic          wrStatus;
    logic          wrCause;
    logic          wrEpc;
    logic          wrCount;
    logic          wrCompare;
    logic          takeExc;
    logic          capBadVaddr;
    logic          exl;
    logic          timerHit;
    cp0Pkg::word_t status;
    cp0Pkg::word_t cause;
    cp0Pkg::word_t epc;
    cp0Pkg::word_t badVaddr;
    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;

    cp0ExcCtrl cp0ExcCtrl_i (
        .clk(clk), .rst(rst),
        .cp0Wen_i(cp0Wen_i), .cp0Addr_i(cp0Addr_i), .cp0WrData_i(cp0WrData_i),
        .excValid_i(excValid_i), .excDelaySlot_i(excDelaySlot_i),
        .eret_i(eret_i), .excCode_i(excCode_i),
        .status_i(status), .cause_i(cause), .epc_i(epc),
        .badVaddr_i(badVaddr), .count_i(count), .compare_i(compare),
        .wrStatus_o(wrStatus), .wrCause_o(wrCause), .wrEpc_o(wrEpc),
        .wrCount_o(wrCount), .wrCompare_o(wrCompare),
        .takeExc_o(takeExc), .capBadVaddr_o(capBadVaddr), .exl_o(exl),
        .cp0RdData_o(cp0RdData_o), .cp0ExcOccur_o(cp0ExcOccur_o),
        .cp0ExcDestPc_o(cp0ExcDestPc_o)
    );

    cp0StatusCause cp0StatusCause_i (
        .clk(clk), .rst(rst),
        .wrStatus_i(wrStatus), .wrCause_i(wrCause), .wrData_i(cp0WrData_i),
        .takeExc_i(takeExc), .excDelaySlot_i(excDelaySlot_i),
        .timerHit_i(timerHit), .wrCompare_i(wrCompare), .exl_i(exl),
        .excCode_i(excCode_i), .extInt_i(extInt_i),
        .status_o(status), .cause_o(cause)
    );

    cp0Timer cp0Timer_i (
        .clk(clk), .rst(rst),
        .wrCount_i(wrCount), .wrCompare_i(wrCompare), .wrData_i(cp0WrData_i),
        .count_o(count), .compare_o(compare), .timerHit_o(timerHit)
    );

    cp0ExcRegs cp0ExcRegs_i (
        .clk(clk),
        .takeExc_i(takeExc), .capBadVaddr_i(capBadVaddr), .wrEpc_i(wrEpc),
        .excDelaySlot_i(excDelaySlot_i), .excPc_i(excPc_i),
        .excBadVaddr_i(excBadVaddr_i), .wrData_i(cp0WrData_i),
        .epc_o(epc), .badVaddr_o(badVaddr)
    );

    assign cp0Status_o = status;
    assign cp0Cause_o  = cause;

endmodule

//--- cp0_assertions.sv
// CP0 control checks on redirect legality and exception entry, bound to the control block
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0Assertions (
    input logic          clk,
    input logic          rst,
    input logic          eret_i,
    input logic          wrStatus_i,
    input logic          takeExc_i,
    input logic          exl_i,
    input logic          excOccur_i,
    input cp0Pkg::word_t excDestPc_i
);

    // ------------------------------
    // redirect
    // ------------------------------
    // a flush needs eret or a fresh exception outside a handler
    redirectLegal: assert property (@(posedge clk) disable iff (!rst)
        excOccur_i |-> (eret_i || !exl_i))
        else $error("redirect raised while EXL set and no eret");

    exceptionVector: assert property (@(posedge clk) disable iff (!rst)
        takeExc_i |-> (excDestPc_i == `CP0_EXC_VECTOR))
        else $error("exception redirect does not target the vector");

    // ------------------------------
    // EXL on entry
    // ------------------------------
    // a Status write in the same cycle overrides the entry
    exlOnEntry: assert property (@(posedge clk) disable iff (!rst)
        (takeExc_i && !wrStatus_i) |=> exl_i)
        else $error("EXL not set after exception entry");

endmodule

bind cp0ExcCtrl cp0Assertions cp0AssertionsBind (
    .clk(clk),
    .rst(rst),
    .eret_i(eret_i),
    .wrStatus_i(wrStatus_o),
    .takeExc_i(takeExc_o),
    .exl_i(exl_o),
    .excOccur_i(cp0ExcOccur_o),
    .excDestPc_i(cp0ExcDestPc_o)
);

//--- cp0_consts.svh
// CP0 constants: register positions, field bit positions, exception codes and vector
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// ------------------------------
// register positions {rd, sel}
// ------------------------------
`define CP0_ADDR_BADVADDR 8'h40
`define CP0_ADDR_COUNT    8'h48
`define CP0_ADDR_COMPARE  8'h58
`define CP0_ADDR_STATUS   8'h60
`define CP0_ADDR_CAUSE    8'h68
`define CP0_ADDR_EPC      8'h70

// fixed entry point for all exceptions
`define CP0_EXC_VECTOR    32'hBFC00380

// codes that report a faulting address
`define EXC_MOD           5'h01
`define EXC_TLBL          5'h02
`define EXC_TLBS          5'h03
`define EXC_ADEL          5'h04
`define EXC_ADES          5'h05

// ------------------------------
// field bit positions
// ------------------------------
`define STATUS_IE         0
`define STATUS_EXL        1
`define STATUS_IM_LO      8
`define STATUS_IM_HI      15
`define CP0_STATUS_BEV    22
`define CAUSE_EXC_LO      2
`define CAUSE_EXC_HI      6
`define CAUSE_IP_LO       8
`define CAUSE_IP_HI       15
`define CAUSE_TI          30
`define CAUSE_BD          31

`endif

//--- run.sh
#!/bin/sh
# compile the CP0 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cp0Tb -f build.f -o cp0Sim || exit 1
simOut=$(./obj_dir/cp0Sim)
echo "$simOut"
echo "$simOut" | grep -qx "PASS: all tests" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
